// ==== design/bit_packer.sv ====
// ==================================================
// bit packer
// header build and lsb-first packing of coder words
// ==================================================
module bit_packer
    import lc3_frame_pkg::*;
    import pack_stream_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  frame_dur_t        frame_duration,
    input  logic              channel_mode,
    input  logic [7:0]        target_bitrate,
    input  logic [15:0]       sample_rate,
    input  logic              enable,
    input  logic              entropy_valid,
    input  logic [WORD_W-1:0] entropy_bits,
    input  logic [CNT_W-1:0]  entropy_bit_count,
    input  logic              entropy_frame_end,
    output logic              entropy_ready,
    byte_stream_if.src        out
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_COLLECT,
        ST_FLUSH
    } state_t;

    state_t                                 state;
    logic [WORD_W+HDR_BYTES*BYTE_W-1:0]     acc;          // bits above bit_cnt stay zero
    logic [CNT_W-1:0]                       bit_cnt;
    logic [WORD_W-1:0]                      word_masked;
    frame_header_t                          hdr;
    logic                                   last_byte;
    logic                                   take_word;
    logic                                   take_byte;

    // header from the live config, captured into acc on the first word
    assign hdr = encode_header(frame_duration, target_bitrate, sample_rate, channel_mode);

    // keep only the low entropy_bit_count bits
    assign word_masked = entropy_bits & ({WORD_W{1'b1}} >> (WORD_W - entropy_bit_count));

    always_comb begin
        case (state)
            ST_IDLE:    entropy_ready = enable;
            ST_COLLECT: entropy_ready = (bit_cnt < BYTE_W);
            default:    entropy_ready = 1'b0;
        endcase
    end

    assign take_word = entropy_valid && entropy_ready;

    // ==================================================
    // byte output
    // ==================================================
    assign last_byte = (state == ST_FLUSH) && (bit_cnt <= BYTE_W);

    always_comb begin
        if (state == ST_FLUSH) begin
            out.valid = (bit_cnt != '0);   // partial byte allowed, zero padded
        end else begin
            out.valid = (bit_cnt >= BYTE_W);
        end
    end

    assign out.data  = {last_byte, acc[BYTE_W-1:0]};
    assign take_byte = out.valid && out.ready;

    // ==================================================
    // accumulator and FSM
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= ST_IDLE;
            acc     <= '0;
            bit_cnt <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (take_word) begin
                        acc     <= {word_masked, hdr};   // header low byte goes out first
                        bit_cnt <= CNT_W'(HDR_BYTES * BYTE_W) + entropy_bit_count;
                        state   <= entropy_frame_end ? ST_FLUSH : ST_COLLECT;
                    end
                end

                ST_COLLECT: begin
                    if (take_byte) begin
                        acc     <= acc >> BYTE_W;
                        bit_cnt <= bit_cnt - CNT_W'(BYTE_W);
                    end else if (take_word) begin
                        // append above the bits already held
                        acc     <= acc | ({{(HDR_BYTES*BYTE_W){1'b0}}, word_masked} << bit_cnt);
                        bit_cnt <= bit_cnt + entropy_bit_count;
                        if (entropy_frame_end) begin
                            state <= ST_FLUSH;
                        end
                    end
                end

                ST_FLUSH: begin
                    if (take_byte) begin
                        acc <= acc >> BYTE_W;
                        if (last_byte) begin
                            bit_cnt <= '0;
                            state   <= ST_IDLE;
                        end else begin
                            bit_cnt <= bit_cnt - CNT_W'(BYTE_W);
                        end
                    end
                end

                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

// ==== design/bitstream_packing_top.sv ====
// ==================================================
// bitstream packing top
// packer -> byte FIFO -> CRC framer
// ==================================================
module bitstream_packing_top
    import lc3_frame_pkg::*;
    import pack_stream_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,

    // configuration
    input  frame_dur_t        frame_duration,
    input  logic              channel_mode,
    input  logic [7:0]        target_bitrate,
    input  logic [15:0]       sample_rate,
    input  logic              enable,

    // entropy coder side
    input  logic              entropy_valid,
    input  logic [WORD_W-1:0] entropy_bits,
    input  logic [CNT_W-1:0]  entropy_bit_count,
    input  logic              entropy_frame_end,
    output logic              entropy_ready,

    // byte output
    output logic              output_valid,
    output logic [BYTE_W-1:0] output_byte,
    input  logic              output_ready,
    output logic              frame_start,
    output logic              frame_complete,
    output logic [SIZE_W-1:0] frame_size_bytes,
    output logic [7:0]        crc_value
);

    byte_stream_if pk2fifo (.clk(clk));
    byte_stream_if fifo2fr (.clk(clk));

    bit_packer u_packer (
        .clk               (clk),
        .rst_n             (rst_n),
        .frame_duration    (frame_duration),
        .channel_mode      (channel_mode),
        .target_bitrate    (target_bitrate),
        .sample_rate       (sample_rate),
        .enable            (enable),
        .entropy_valid     (entropy_valid),
        .entropy_bits      (entropy_bits),
        .entropy_bit_count (entropy_bit_count),
        .entropy_frame_end (entropy_frame_end),
        .entropy_ready     (entropy_ready),
        .out               (pk2fifo.src)
    );

    byte_fifo u_fifo (
        .clk   (clk),
        .rst_n (rst_n),
        .in    (pk2fifo.snk),
        .out   (fifo2fr.src)
    );

    crc_framer u_framer (
        .clk              (clk),
        .rst_n            (rst_n),
        .in               (fifo2fr.snk),
        .output_valid     (output_valid),
        .output_byte      (output_byte),
        .output_ready     (output_ready),
        .frame_start      (frame_start),
        .frame_complete   (frame_complete),
        .frame_size_bytes (frame_size_bytes),
        .crc_value        (crc_value)
    );

endmodule

// ==== design/byte_fifo.sv ====
// ==================================================
// byte FIFO
// circular buffer with registered output stage
// ==================================================
module byte_fifo
    import pack_stream_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    byte_stream_if.snk in,
    byte_stream_if.src out
);

    stream_byte_t       mem [FIFO_DEPTH];
    logic [FIFO_AW-1:0] wr_ptr;
    logic [FIFO_AW-1:0] rd_ptr;
    logic [FIFO_AW:0]   count;       // entries in mem, not counting the stage
    logic               out_valid;
    stream_byte_t       out_data;
    logic               push;
    logic               stage_free;
    logic               load_mem;
    logic               bypass;
    logic               write_mem;

    assign in.ready   = (count != (FIFO_AW+1)'(FIFO_DEPTH));
    assign out.valid  = out_valid;
    assign out.data   = out_data;

    assign push       = in.valid && in.ready;
    assign stage_free = !out_valid || out.ready;
    assign load_mem   = stage_free && (count != '0);
    assign bypass     = stage_free && (count == '0) && push;   // straight into the stage
    assign write_mem  = push && !bypass;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            out_valid <= 1'b0;
        end else begin
            if (write_mem) wr_ptr <= wr_ptr + 1'b1;
            if (load_mem) rd_ptr <= rd_ptr + 1'b1;
            count <= count + (FIFO_AW+1)'(write_mem) - (FIFO_AW+1)'(load_mem);
            if (stage_free) begin
                out_valid <= load_mem || bypass;
            end
        end
    end

    // storage and output stage data
    always_ff @(posedge clk) begin
        if (write_mem) begin
            mem[wr_ptr] <= in.data;
        end
        if (load_mem) begin
            out_data <= mem[rd_ptr];
        end else if (bypass) begin
            out_data <= in.data;
        end
    end

endmodule

// ==== design/byte_stream_if.sv ====
// ==================================================
// byte stream interface
// one byte with frame-end mark, valid/ready handshake
// ==================================================
interface byte_stream_if
    import pack_stream_pkg::*;
(
    input logic clk
);

    logic         valid;
    logic         ready;
    stream_byte_t data;

    // transfer on posedge with valid && ready
    modport src (
        input  clk, ready,
        output valid, data
    );

    modport snk (
        input  clk, valid, data,
        output ready
    );

endinterface

// ==== design/crc_framer.sv ====
// ==================================================
// CRC framer
// byte output, CRC-8 append and frame reporting
// ==================================================
module crc_framer
    import lc3_frame_pkg::*;
    import pack_stream_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    byte_stream_if.snk        in,
    output logic              output_valid,
    output logic [BYTE_W-1:0] output_byte,
    input  logic              output_ready,
    output logic              frame_start,
    output logic              frame_complete,
    output logic [SIZE_W-1:0] frame_size_bytes,
    output logic [7:0]        crc_value
);

    logic              held_last;     // held byte is the last data byte
    logic              held_crc;      // held byte is the CRC
    logic              first_pending; // next data byte opens a frame
    logic [7:0]        crc;
    logic [7:0]        crc_next;
    logic [SIZE_W-1:0] byte_cnt;
    logic              xfer;
    logic              pop;

    assign xfer     = output_valid && output_ready;
    assign crc_next = crc8_update(crc, output_byte);

    // reload the register when empty or draining, except while the CRC goes in
    assign in.ready = !output_valid || (xfer && !held_last);
    assign pop      = in.valid && in.ready;

    assign frame_start = xfer && first_pending && !held_crc;

    // ==================================================
    // control
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            output_valid     <= 1'b0;
            held_last        <= 1'b0;
            held_crc         <= 1'b0;
            first_pending    <= 1'b1;
            crc              <= CRC8_INIT;
            byte_cnt         <= '0;
            frame_complete   <= 1'b0;
            frame_size_bytes <= '0;
            crc_value        <= '0;
        end else begin
            frame_complete <= xfer && held_crc;

            if (xfer && held_crc) begin
                // frame closed, publish and restart
                frame_size_bytes <= byte_cnt + 1'b1;
                crc_value        <= output_byte;
                crc              <= CRC8_INIT;
                byte_cnt         <= '0;
                first_pending    <= 1'b1;
            end else if (xfer) begin
                crc           <= crc_next;
                byte_cnt      <= byte_cnt + 1'b1;
                first_pending <= 1'b0;
            end

            if (pop) begin
                output_valid <= 1'b1;
                held_last    <= in.data.last;
                held_crc     <= 1'b0;
            end else if (xfer && held_last) begin
                held_last <= 1'b0;
                held_crc  <= 1'b1;   // valid stays up for the CRC byte
            end else if (xfer) begin
                output_valid <= 1'b0;
                held_crc     <= 1'b0;
            end
        end
    end

    // output byte register
    always_ff @(posedge clk) begin
        if (pop) begin
            output_byte <= in.data.data;
        end else if (xfer && held_last) begin
            output_byte <= crc_next;   // crc over every data byte
        end
    end

endmodule

// ==== design/lc3_frame_pkg.sv ====
// ==================================================
// lc3 frame format package
// header field types, constants and encoders, CRC-8
// ==================================================
package lc3_frame_pkg;

    typedef logic [1:0] frame_dur_t;   // frame duration code
    typedef logic [1:0] sr_idx_t;      // sample-rate index
    typedef logic [3:0] br_idx_t;      // bitrate index

    // 16-bit header, msb first
    typedef struct packed {
        logic [1:0] sync;
        logic [2:0] ftype;
        sr_idx_t    sr_idx;
        frame_dur_t dur;
        br_idx_t    br_idx;
        logic       ch_mode;
        logic [1:0] flags;
    } frame_header_t;

    localparam logic [1:0] SYNC_WORD        = 2'b10;
    localparam logic [2:0] FRAME_TYPE_AUDIO = 3'd0;
    localparam logic [1:0] HDR_FLAGS        = 2'b01;
    localparam logic [7:0] CRC8_POLY        = 8'h07;   // x^8 + x^2 + x + 1
    localparam logic [7:0] CRC8_INIT        = 8'hFF;
    localparam int         HDR_BYTES        = 2;

    function automatic sr_idx_t encode_sr_idx(input logic [15:0] sample_rate);
        case (sample_rate)
            16'd8000:  return 2'd0;
            16'd16000: return 2'd1;
            16'd24000: return 2'd2;
            default:   return 2'd3;   // 48k and anything unknown
        endcase
    endfunction

    function automatic br_idx_t encode_br_idx(input logic [7:0] target_bitrate);
        if (target_bitrate <= 8'd32) return 4'd2;
        if (target_bitrate <= 8'd64) return 4'd4;
        if (target_bitrate <= 8'd128) return 4'd8;
        return 4'd12;
    endfunction

    function automatic frame_header_t encode_header(input frame_dur_t dur,
                                                    input logic [7:0] target_bitrate,
                                                    input logic [15:0] sample_rate,
                                                    input logic ch_mode);
        frame_header_t h;
        h.sync    = SYNC_WORD;
        h.ftype   = FRAME_TYPE_AUDIO;
        h.sr_idx  = encode_sr_idx(sample_rate);
        h.dur     = dur;
        h.br_idx  = encode_br_idx(target_bitrate);
        h.ch_mode = ch_mode;
        h.flags   = HDR_FLAGS;
        return h;
    endfunction

    // one byte of CRC-8, msb first
    function automatic logic [7:0] crc8_update(input logic [7:0] crc, input logic [7:0] data);
        logic [7:0] c;
        c = crc ^ data;
        for (int i = 0; i < 8; i++) begin
            c = c[7] ? ((c << 1) ^ CRC8_POLY) : (c << 1);
        end
        return c;
    endfunction

endpackage

// ==== design/pack_stream_pkg.sv ====
// ==================================================
// byte stream package
// widths, FIFO sizing and the stream entry type
// ==================================================
package pack_stream_pkg;

    localparam int BYTE_W     = 8;
    localparam int WORD_W     = 32;   // coder word
    localparam int CNT_W      = 6;    // bit counts, up to 63
    localparam int FIFO_DEPTH = 16;
    localparam int FIFO_AW    = 4;
    localparam int SIZE_W     = 16;

    // one byte plus frame-end mark
    typedef struct packed {
        logic              last;
        logic [BYTE_W-1:0] data;
    } stream_byte_t;

endpackage

// ==== files.f ====
design/lc3_frame_pkg.sv
design/pack_stream_pkg.sv
design/byte_stream_if.sv
design/bit_packer.sv
design/byte_fifo.sv
design/crc_framer.sv
design/bitstream_packing_top.sv
testbench/bitstream_packing_asserts.sv
testbench/tb_bitstream_packing.sv

// ==== testbench/bitstream_packing_asserts.sv ====
// ==================================================
// output port protocol assertions
// bound into the packing top level
// ==================================================
module bitstream_packing_asserts
    import pack_stream_pkg::*;
(
    input logic              clk,
    input logic              rst_n,
    input logic              output_valid,
    input logic [BYTE_W-1:0] output_byte,
    input logic              output_ready,
    input logic              frame_complete
);
    timeunit 1ns;
    timeprecision 100ps;

    // held byte stays put under back-pressure
    a_hold_byte: assert property (@(posedge clk) disable iff (!rst_n)
        output_valid && !output_ready |=> output_valid && $stable(output_byte))
        else $error("output byte dropped or changed while output_ready was low");

    a_complete_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        frame_complete |=> !frame_complete)
        else $error("frame_complete stayed high for two cycles");

endmodule

bind bitstream_packing_top bitstream_packing_asserts u_asserts (.*);

// ==== testbench/tb_bitstream_packing.sv ====
// ==================================================
// bitstream packing testbench
// table-driven frames checked against a byte model
// ==================================================
module tb_bitstream_packing
    import pack_stream_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NROWS  = 10;
    localparam int NWORDS = 25;

    typedef struct packed {
        logic [1:0]  dur;
        logic        ch;
        logic [7:0]  br;
        logic [15:0] sr;
        logic [1:0]  exp_sr;    // expected header indices
        logic [3:0]  exp_br;
        logic [7:0]  first;     // first entry in the word table
        logic [3:0]  n_words;
        logic        stall;     // random output_ready
        logic        en_gap;    // hold enable low before the frame
    } row_t;

    // dur ch br sr | exp_sr exp_br | first n_words | stall en_gap
    row_t rows [NROWS] = '{
        '{2'd0, 1'b0, 8'd24,  16'd8000,  2'd0, 4'd2,  8'd0,  4'd1, 1'b0, 1'b1},
        '{2'd1, 1'b1, 8'd48,  16'd16000, 2'd1, 4'd4,  8'd1,  4'd3, 1'b0, 1'b0},
        '{2'd2, 1'b0, 8'd100, 16'd24000, 2'd2, 4'd8,  8'd4,  4'd4, 1'b0, 1'b0},
        '{2'd3, 1'b1, 8'd200, 16'd48000, 2'd3, 4'd12, 8'd8,  4'd4, 1'b0, 1'b0},
        '{2'd3, 1'b1, 8'd200, 16'd48000, 2'd3, 4'd12, 8'd8,  4'd4, 1'b1, 1'b0},
        '{2'd2, 1'b0, 8'd100, 16'd24000, 2'd2, 4'd8,  8'd4,  4'd4, 1'b1, 1'b1},
        '{2'd1, 1'b0, 8'd32,  16'd44100, 2'd3, 4'd2,  8'd12, 4'd6, 1'b1, 1'b0},
        '{2'd0, 1'b1, 8'd64,  16'd16000, 2'd1, 4'd4,  8'd18, 4'd2, 1'b0, 1'b0},
        '{2'd2, 1'b1, 8'd128, 16'd8000,  2'd0, 4'd8,  8'd20, 4'd3, 1'b1, 1'b1},
        '{2'd3, 1'b0, 8'd129, 16'd24000, 2'd2, 4'd12, 8'd23, 4'd2, 1'b0, 1'b0}
    };

    logic [WORD_W-1:0] word_bits [NWORDS] = '{
        32'h000000A5, 32'h00000001, 32'h000003FF, 32'hDEADBEEF,
        32'h01234567, 32'h00000005, 32'h0000007F, 32'hFFFFFFF0,   // last one masks to 0
        32'hFFFFFFFF, 32'hABCDEF01, 32'h13579BDF, 32'h00000002,
        32'h00000006, 32'h0000001F, 32'h00000ACE, 32'h00000001, 32'hFEDCBA98, 32'h00000003,
        32'h87654321, 32'h12345678, 32'h55555555, 32'hAAAAAAAA, 32'hFFFFFFFF,
        32'h000000C3, 32'h0000003C
    };
    logic [CNT_W-1:0] word_cnt [NWORDS] = '{
        6'd8,  6'd1,  6'd10, 6'd32,
        6'd25, 6'd3,  6'd7,  6'd4,
        6'd32, 6'd32, 6'd31, 6'd2,
        6'd3,  6'd5,  6'd12, 6'd1,  6'd32, 6'd2,
        6'd20, 6'd16, 6'd17, 6'd32, 6'd1,
        6'd8,  6'd8
    };

    logic              clk;
    logic              rst_n;
    logic [1:0]        frame_duration;
    logic              channel_mode;
    logic [7:0]        target_bitrate;
    logic [15:0]       sample_rate;
    logic              enable;
    logic              entropy_valid;
    logic [WORD_W-1:0] entropy_bits;
    logic [CNT_W-1:0]  entropy_bit_count;
    logic              entropy_frame_end;
    logic              entropy_ready;
    logic              output_valid;
    logic [BYTE_W-1:0] output_byte;
    logic              output_ready;
    logic              frame_start;
    logic              frame_complete;
    logic [SIZE_W-1:0] frame_size_bytes;
    logic [7:0]        crc_value;

    logic [7:0]  exp_q[$];          // expected bytes of all queued frames
    int          size_q[$];
    int          errors       = 0;
    int          frames_built = 0;
    int          frames_done  = 0;
    logic        stall_mode   = 1'b0;
    logic [31:0] rng          = 32'd93243;

    bitstream_packing_top i_bitstream_packing_top (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    // bit-serial CRC-8, poly 07, msb first
    function automatic logic [7:0] crc_serial(input logic [7:0] crc, input logic [7:0] b);
        logic [7:0] c;
        logic       fb;
        c = crc;
        for (int i = 7; i >= 0; i--) begin
            fb = c[7] ^ b[i];
            c  = {c[6:0], 1'b0} ^ (fb ? 8'h07 : 8'h00);
        end
        return c;
    endfunction

    task automatic log_err(input string msg);
        errors++;
        $display("ERR %0t: %s", $time, msg);
    endtask

    // ==================================================
    // reference model
    // ==================================================
    task automatic build_frame(input int r);
        logic [15:0] hdr;
        logic [7:0]  bytes[$];
        logic [7:0]  cur;
        logic [7:0]  crc;
        int          pos;
        int          w;
        hdr = {2'b10, 3'b000, rows[r].exp_sr, rows[r].dur, rows[r].exp_br, rows[r].ch, 2'b01};
        bytes.push_back(hdr[7:0]);   // low byte first
        bytes.push_back(hdr[15:8]);
        cur = '0;
        pos = 0;
        for (int k = 0; k < rows[r].n_words; k++) begin
            w = rows[r].first + k;
            for (int b = 0; b < word_cnt[w]; b++) begin
                cur[pos] = word_bits[w][b];
                pos++;
                if (pos == 8) begin
                    bytes.push_back(cur);
                    cur = '0;
                    pos = 0;
                end
            end
        end
        if (pos != 0) bytes.push_back(cur);   // zero padded tail
        crc = 8'hFF;
        foreach (bytes[i]) crc = crc_serial(crc, bytes[i]);
        bytes.push_back(crc);
        foreach (bytes[i]) exp_q.push_back(bytes[i]);
        size_q.push_back(bytes.size());
        frames_built++;
    endtask

    // ==================================================
    // stimulus
    // ==================================================
    task automatic send_word(input int w, input logic last);
        entropy_valid     = 1'b1;
        entropy_bits      = word_bits[w];
        entropy_bit_count = word_cnt[w];
        entropy_frame_end = last;
        do @(negedge clk); while (!entropy_ready);
        @(posedge clk);   // accepted here
        #1;
    endtask

    initial begin
        rst_n = 1'b0;
        {frame_duration, channel_mode, target_bitrate, sample_rate} = '0;
        {enable, entropy_valid, entropy_bits, entropy_bit_count, entropy_frame_end} = '0;
        output_ready = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
        for (int r = 0; r < NROWS; r++) begin
            if (rows[r].en_gap) begin
                wait (frames_done == frames_built);
                @(posedge clk);
                #1;
                enable        = 1'b0;
                entropy_valid = 1'b1;   // offered but must not be taken
                repeat (6) begin
                    @(negedge clk);
                    assert (!entropy_ready && !output_valid)
                        else log_err("activity while enable low in idle");
                end
                @(posedge clk);
                #1;
            end
            build_frame(r);
            stall_mode     = rows[r].stall;
            frame_duration = rows[r].dur;
            channel_mode   = rows[r].ch;
            target_bitrate = rows[r].br;
            sample_rate    = rows[r].sr;
            enable         = 1'b1;
            for (int k = 0; k < rows[r].n_words; k++) begin
                send_word(rows[r].first + k, k == rows[r].n_words - 1);
                frame_duration = ~rows[r].dur;   // header already latched
                channel_mode   = ~rows[r].ch;
                target_bitrate = ~rows[r].br;
                sample_rate    = 16'd12345;
            end
            entropy_valid = 1'b0;
        end
        wait (frames_done == NROWS);
        repeat (4) @(posedge clk);
        assert (exp_q.size() == 0) else begin
            errors++;
            $display("%0d expected bytes never came out", exp_q.size());
        end
        $display("errors: %0d, frames checked: %0d", errors, frames_done);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    // output_ready, random only in stall rows
    initial begin
        wait (rst_n === 1'b1);
        forever begin
            @(posedge clk);
            #1;
            if (stall_mode) begin
                rng          = xorshift32(rng);
                output_ready = rng[7] & rng[3];
            end else begin
                output_ready = 1'b1;
            end
        end
    end

    // ==================================================
    // monitor
    // ==================================================
    int         byte_idx     = 0;
    int         cur_size     = 0;
    int         last_size    = 0;
    logic       complete_due = 1'b0;
    logic [7:0] last_crc;
    logic [7:0] exp_byte;

    always @(negedge clk) begin
        if (rst_n === 1'b1) begin
            assert (frame_complete == complete_due)
                else log_err($sformatf("frame_complete %0b, expected %0b",
                                       frame_complete, complete_due));
            if (complete_due) begin
                assert (frame_size_bytes == last_size && crc_value == last_crc)
                    else log_err($sformatf("size %0d crc %02h, expected %0d %02h",
                                           frame_size_bytes, crc_value, last_size, last_crc));
                frames_done++;
            end
            complete_due = 1'b0;
            assert (frame_start == (output_valid && output_ready && byte_idx == 0))
                else log_err($sformatf("frame_start %0b at byte %0d", frame_start, byte_idx));
            if (output_valid && output_ready) begin
                assert (exp_q.size() != 0)
                    else log_err($sformatf("unexpected output byte %02h, no frame pending",
                                           output_byte));
                if (exp_q.size() != 0) begin
                    if (byte_idx == 0) cur_size = size_q.pop_front();
                    exp_byte = exp_q.pop_front();
                    assert (output_byte == exp_byte)
                        else log_err($sformatf("frame %0d byte %0d is %02h, expected %02h",
                                               frames_done, byte_idx, output_byte, exp_byte));
                    byte_idx++;
                    if (byte_idx == cur_size) begin   // CRC byte goes out
                        complete_due = 1'b1;
                        last_size    = cur_size;
                        last_crc     = exp_byte;
                        byte_idx     = 0;
                    end
                end
            end
        end
    end

    // watchdog
    initial begin
        #(NROWS * 2000);
        $display("watchdog expired, the run hung with %0d of %0d frames done",
                 frames_done, NROWS);
        $display("=== FAIL ===");
        $finish;
    end

endmodule
